/* logic/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// instruction memory address width for 256 words
`define MIPS_IMEM_AW 8

// data path width
`define MIPS_XLEN 32

// program counter counts words, so two bits fewer than a byte address
`define MIPS_PC_W 30

`endif

/* logic/mips_pkg.sv */
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;     // data word
    typedef logic [31:0]           instr_t;    // raw instruction
    typedef logic [`MIPS_PC_W-1:0] pc_t;       // word address
    typedef logic [4:0]            reg_idx_t;  // register number

    // ALU function selected by decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,   // signed compare
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,   // immediate into upper half
        ALU_NONE   // result forced to zero
    } alu_op_e;

    // control transfer kind resolved in execute
    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JUMP
    } br_kind_e;

endpackage

`default_nettype wire

/* logic/stage_if.sv */
`default_nettype none

// fetch to decode with stall back from decode and redirect from execute
interface fetch_if
    import mips_pkg::*;
();
    logic   valid;
    instr_t instr;
    pc_t    pc;
    logic   stall;
    logic   load;
    pc_t    target;

    modport fetch   (output valid, instr, pc, input stall, load, target);
    modport decode  (input valid, instr, pc, load, output stall);
    modport execute (output load, target);
endinterface

// decode to execute pipeline register
interface dec_exe_if
    import mips_pkg::*;
();
    logic     valid;
    pc_t      pc;
    alu_op_e  alu_op;
    br_kind_e br_kind;
    word_t    op_a;
    word_t    op_b;
    word_t    store_b;   // rt value for the branch compare
    reg_idx_t dest;
    logic     reg_we;
    pc_t      target;

    modport decode  (output valid, pc, alu_op, br_kind, op_a, op_b, store_b, dest, reg_we,
                     target);
    modport execute (input valid, pc, alu_op, br_kind, op_a, op_b, store_b, dest, reg_we,
                     target);
endinterface

// execute to result pipeline register
interface exe_res_if
    import mips_pkg::*;
();
    logic     valid;
    pc_t      pc;
    reg_idx_t dest;
    logic     reg_we;
    word_t    data;

    modport execute (output valid, pc, dest, reg_we, data);
    modport result  (input valid, pc, dest, reg_we, data);
endinterface

`default_nettype wire

/* logic/ifetch.sv */
`default_nettype none

`include "mips_cfg.svh"

module ifetch
    import mips_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    run,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  pc_t     wb_adr,
    input  word_t   wb_dat_w,
    output word_t   wb_dat_r,
    output logic    wb_ack,
    fetch_if.fetch  fe
);

    localparam int unsigned IMEM_WORDS = 1 << `MIPS_IMEM_AW;

    word_t imem [IMEM_WORDS];

    pc_t  pc;        // address of the next word to read
    pc_t  next_pc;
    logic fetch_en;
    logic wb_req;
    logic ack_q;

    assign fetch_en = run && !fe.stall && !fe.load;

    // target wins over stall, stall and run low both hold
    always_comb begin
        if (fe.load) begin
            next_pc = fe.target;
        end else if (fetch_en) begin
            next_pc = pc + 1'b1;
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            fe.valid <= 1'b0;
        end else begin
            pc <= next_pc;
            if (fe.load) begin
                fe.valid <= 1'b0;       // redirected with nothing to present yet
            end else if (!fe.stall) begin
                fe.valid <= run;
            end
        end
    end

    // port A is read only and registers the address with the word
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fe.instr <= imem[pc[`MIPS_IMEM_AW-1:0]];
            fe.pc    <= pc;
        end
    end

    // port B is a Wishbone classic slave for loading and readback
    assign wb_req = wb_cyc && wb_stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req;            // single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            if (wb_we) begin
                imem[wb_adr[`MIPS_IMEM_AW-1:0]] <= wb_dat_w;
            end
            wb_dat_r <= imem[wb_adr[`MIPS_IMEM_AW-1:0]];
        end
    end

    assign wb_ack = ack_q;

endmodule

`default_nettype wire

/* logic/decode.sv */
`default_nettype none

module decode
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    fetch_if.decode   fe,
    dec_exe_if.decode de,
    output reg_idx_t  rd_a,
    output reg_idx_t  rd_b,
    input  word_t     rd_data_a,
    input  word_t     rd_data_b,
    input  reg_idx_t  exe_dest,
    input  logic      exe_we
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_idx_t    rs, rt, rd;
    logic [4:0]  sa;
    logic [15:0] imm;
    logic [25:0] instr_index;

    alu_op_e  alu_op;
    br_kind_e br_kind;
    word_t    op_a, op_b;
    reg_idx_t dest;
    logic     reg_we, use_rs, use_rt;
    logic     stall, issue;
    pc_t      pc_inc, target;

    assign opcode      = fe.instr[31:26];
    assign rs          = fe.instr[25:21];
    assign rt          = fe.instr[20:16];
    assign rd          = fe.instr[15:11];
    assign sa          = fe.instr[10:6];
    assign imm         = fe.instr[15:0];
    assign instr_index = fe.instr[25:0];
    assign funct       = fe.instr[5:0];

    // register file addressed straight from the fields
    assign rd_a = rs;
    assign rd_b = rt;

    assign pc_inc = fe.pc + 1'b1;

    always_comb begin
        alu_op  = ALU_NONE;
        br_kind = BR_NONE;
        op_a    = rd_data_a;
        op_b    = rd_data_b;
        dest    = rt;
        reg_we  = 1'b0;
        use_rs  = 1'b0;
        use_rt  = 1'b0;
        target  = pc_inc + pc_t'($signed(imm));   // branch target
        case (opcode)
            OP_SPECIAL: begin
                dest   = rd;
                reg_we = 1'b1;
                use_rs = 1'b1;
                use_rt = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL, FN_SRL: begin
                        alu_op = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        op_a   = word_t'(sa);     // shift amount rides on op_a
                        use_rs = 1'b0;
                    end
                    default: begin                // unknown funct retires as a nop
                        reg_we = 1'b0;
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI: begin
                reg_we = 1'b1;
                use_rs = 1'b1;
                op_b   = word_t'(imm);            // zero extend for the logic ops
                case (opcode)
                    OP_ADDIU: begin
                        alu_op = ALU_ADD;
                        op_b   = word_t'($signed(imm));
                    end
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    default: alu_op = ALU_XOR;
                endcase
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                op_b   = word_t'(imm);
                reg_we = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                br_kind = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                use_rs  = 1'b1;
                use_rt  = 1'b1;
            end
            OP_J: begin
                br_kind = BR_JUMP;
                target  = pc_t'({pc_inc[$bits(pc_t)-1:26], instr_index});
            end
            default: ;                            // nop with no write
        endcase
    end

    // the only hazard left is the instruction in execute
    assign stall = fe.valid && exe_we && (exe_dest != '0) &&
                   ((use_rs && rs == exe_dest) || (use_rt && rt == exe_dest));
    assign fe.stall = stall;

    assign issue = fe.valid && !stall && !fe.load;

    always_ff @(posedge clk) begin
        if (rst) begin
            de.valid  <= 1'b0;
            de.reg_we <= 1'b0;
        end else begin
            de.valid  <= issue;                   // bubble on stall or squash
            de.reg_we <= issue && reg_we;
        end
        de.pc      <= fe.pc;
        de.alu_op  <= alu_op;
        de.br_kind <= br_kind;
        de.op_a    <= op_a;
        de.op_b    <= op_b;
        de.store_b <= rd_data_b;
        de.dest    <= dest;
        de.target  <= target;
    end

endmodule

`default_nettype wire

/* logic/execute.sv */
`default_nettype none

module execute
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    dec_exe_if.execute de,
    fetch_if.execute   fe,
    exe_res_if.execute ex
);

    word_t alu_res;
    logic  equal;
    logic  taken;

    always_comb begin
        case (de.alu_op)
            ALU_ADD: alu_res = de.op_a + de.op_b;
            ALU_SUB: alu_res = de.op_a - de.op_b;
            ALU_AND: alu_res = de.op_a & de.op_b;
            ALU_OR:  alu_res = de.op_a | de.op_b;
            ALU_XOR: alu_res = de.op_a ^ de.op_b;
            ALU_SLT: alu_res = word_t'($signed(de.op_a) < $signed(de.op_b));
            ALU_SLL: alu_res = de.op_b << de.op_a[4:0];
            ALU_SRL: alu_res = de.op_b >> de.op_a[4:0];
            ALU_LUI: alu_res = word_t'({de.op_b[15:0], 16'h0000});
            default: alu_res = '0;                  // branches and nops
        endcase
    end

    // compare rs against rt
    assign equal = (de.op_a == de.store_b);

    always_comb begin
        taken = 1'b0;
        if (de.valid) begin
            case (de.br_kind)
                BR_BEQ:  taken = equal;
                BR_BNE:  taken = !equal;
                BR_JUMP: taken = 1'b1;
                default: taken = 1'b0;
            endcase
        end
    end

    // redirect fetch; decode drops its word on the same edge
    assign fe.load   = taken;
    assign fe.target = de.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid  <= 1'b0;
            ex.reg_we <= 1'b0;
        end else begin
            ex.valid  <= de.valid;
            ex.reg_we <= de.valid && de.reg_we;
        end
        ex.pc   <= de.pc;
        ex.dest <= de.dest;
        ex.data <= alu_res;
    end

endmodule

`default_nettype wire

/* logic/result.sv */
`default_nettype none

module result
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    exe_res_if.result ex,
    output logic      wr_en,
    output reg_idx_t  wr_idx,
    output word_t     wr_data,
    output logic      commit_valid,
    output logic      commit_we,
    output pc_t       commit_pc,
    output reg_idx_t  commit_reg,
    output word_t     commit_data
);

    // r0 is never written
    assign wr_en   = ex.valid && ex.reg_we && (ex.dest != '0);
    assign wr_idx  = ex.dest;
    assign wr_data = ex.data;

    // commit shows up with the register file already updated
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            commit_we    <= 1'b0;
        end else begin
            commit_valid <= ex.valid;
            commit_we    <= wr_en;
        end
        commit_pc   <= ex.pc;
        commit_reg  <= ex.dest;
        commit_data <= ex.data;
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file
    import mips_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t rd_a,
    input  reg_idx_t rd_b,
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [1:31];   // no storage behind r0

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through so decode sees the value result writes this cycle
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_en && wr_idx == idx) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_a);
        rd_data_b = read_port(rd_b);
    end

endmodule

`default_nettype wire

/* logic/mips_core.sv */
`default_nettype none

module mips_core
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     run,
    // Wishbone program load port
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  pc_t      wb_adr,
    input  word_t    wb_dat_w,
    output word_t    wb_dat_r,
    output logic     wb_ack,
    // retired instructions
    output logic     commit_valid,
    output pc_t      commit_pc,
    output logic     commit_we,
    output reg_idx_t commit_reg,
    output word_t    commit_data
);

    fetch_if   fe_bus ();
    dec_exe_if de_bus ();
    exe_res_if ex_bus ();

    reg_idx_t rd_a, rd_b;
    word_t    rd_data_a, rd_data_b;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    ifetch ifetch_inst (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .fe       (fe_bus.fetch)
    );

    decode decode_inst (
        .clk       (clk),
        .rst       (rst),
        .fe        (fe_bus.decode),
        .de        (de_bus.decode),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .exe_dest  (de_bus.dest),     // hazard check against execute
        .exe_we    (de_bus.reg_we)
    );

    execute execute_inst (
        .clk (clk),
        .rst (rst),
        .de  (de_bus.execute),
        .fe  (fe_bus.execute),
        .ex  (ex_bus.execute)
    );

    result result_inst (
        .clk          (clk),
        .rst          (rst),
        .ex           (ex_bus.result),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit_we    (commit_we),
        .commit_pc    (commit_pc),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

endmodule

`default_nettype wire

/* sim/mips_model.sv */
`default_nettype none

// instruction-set model, one instruction per step in program order
package mips_model;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    logic [31:0] model_mem [0:255];
    logic [31:0] model_regs [0:31];
    logic [29:0] model_pc;

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic void model_reset();
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        model_pc = '0;
    endfunction

    function automatic void load_word(input logic [7:0] addr, input logic [31:0] data);
        model_mem[addr] = data;
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] idx);
        return model_regs[idx];
    endfunction

    // executes the word at model_pc and reports what should retire
    function automatic void model_step(output logic [29:0] pc_o, output logic we_o,
                                       output logic [4:0] reg_o, output logic [31:0] data_o);
        logic [31:0] ins, a, b, simm, zimm;
        logic [29:0] next;
        ins  = model_mem[model_pc[7:0]];
        a    = model_regs[ins[25:21]];
        b    = model_regs[ins[20:16]];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        next = model_pc + 30'd1;
        we_o   = 1'b0;
        reg_o  = ins[20:16];
        data_o = '0;
        case (ins[31:26])
            OP_SPECIAL: begin
                reg_o = ins[15:11];
                we_o  = 1'b1;
                case (ins[5:0])
                    FN_ADDU: data_o = a + b;
                    FN_SUBU: data_o = a - b;
                    FN_AND:  data_o = a & b;
                    FN_OR:   data_o = a | b;
                    FN_XOR:  data_o = a ^ b;
                    FN_SLT:  data_o = {31'd0, $signed(a) < $signed(b)};
                    FN_SLL:  data_o = b << ins[10:6];
                    FN_SRL:  data_o = b >> ins[10:6];
                    default: we_o = 1'b0;     // unknown funct
                endcase
            end
            OP_ADDIU: {we_o, data_o} = {1'b1, a + simm};
            OP_ANDI:  {we_o, data_o} = {1'b1, a & zimm};
            OP_ORI:   {we_o, data_o} = {1'b1, a | zimm};
            OP_XORI:  {we_o, data_o} = {1'b1, a ^ zimm};
            OP_LUI:   {we_o, data_o} = {1'b1, ins[15:0], 16'h0000};
            OP_BEQ: begin
                if (a == b) begin
                    next = model_pc + 30'd1 + simm[29:0];
                end
            end
            OP_BNE: begin
                if (a != b) begin
                    next = model_pc + 30'd1 + simm[29:0];
                end
            end
            OP_J: next = {next[29:26], ins[25:0]};
            default: ;                        // any other opcode is a nop
        endcase
        if (reg_o == 5'd0) begin
            we_o = 1'b0;
        end
        if (we_o) begin
            model_regs[reg_o] = data_o;
        end
        pc_o     = model_pc;
        model_pc = next;
    endfunction

endpackage

`default_nettype wire

/* sim/mips_core_tb.sv */
`default_nettype none

module mips_core_tb
    import mips_model::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    localparam int LOOP_ADDR   = 200;                // self loop after 200 instructions
    localparam int WORDS       = LOOP_ADDR + 1;
    localparam int LOAD_CYCLES = 2 * WORDS * 3;      // write plus readback with slack
    localparam int WATCHDOG_NS = (3 + LOAD_CYCLES + 20 * WORDS) * CLK_PERIOD;

    logic        clk, rst, run;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [29:0] wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic        commit_valid, commit_we;
    logic [29:0] commit_pc;
    logic [4:0]  commit_reg;
    logic [31:0] commit_data;

    logic [31:0] prog [0:LOOP_ADDR];
    logic [31:0] seen [0:7];                         // register values taken from commits
    int unsigned lcg_state = 37;

    mips_core mips_core_inst (
        .clk (clk), .rst (rst), .run (run),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .commit_valid (commit_valid), .commit_pc (commit_pc), .commit_we (commit_we),
        .commit_reg (commit_reg), .commit_data (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;                       // low bits are poor
    endfunction

    function automatic logic [31:0] random_instr(input int addr);
        int unsigned kind;
        logic [4:0]  rs, rt, rd, sa;
        logic [15:0] imm;
        int          off, limit;
        kind  = next_rand() % 17;
        rs    = 5'(next_rand() % 8);                 // r0..r7 keeps dependences dense
        rt    = 5'(next_rand() % 8);
        rd    = 5'(next_rand() % 8);
        sa    = 5'(next_rand());
        imm   = 16'(next_rand());
        limit = LOOP_ADDR - addr - 1;                // forward and never past the loop
        off   = int'(next_rand() % 6);
        if (off > limit) begin
            off = limit;
        end
        case (kind)
            0:  return enc_r(rs, rt, rd, 5'd0, FN_ADDU);
            1:  return enc_r(rs, rt, rd, 5'd0, FN_SUBU);
            2:  return enc_r(rs, rt, rd, 5'd0, FN_AND);
            3:  return enc_r(rs, rt, rd, 5'd0, FN_OR);
            4:  return enc_r(rs, rt, rd, 5'd0, FN_XOR);
            5:  return enc_r(rs, rt, rd, 5'd0, FN_SLT);
            6:  return enc_r(5'd0, rt, rd, sa, FN_SLL);
            7:  return enc_r(5'd0, rt, rd, sa, FN_SRL);
            8:  return enc_i(OP_ADDIU, rs, rt, imm);
            9:  return enc_i(OP_ANDI, rs, rt, imm);
            10: return enc_i(OP_ORI, rs, rt, imm);
            11: return enc_i(OP_XORI, rs, rt, imm);
            12: return enc_i(OP_LUI, 5'd0, rt, imm);
            13: return enc_i(OP_BEQ, rs, rt, 16'(off));
            14: return enc_i(OP_BNE, rs, rt, 16'(off));
            15: return enc_j(OP_J, 26'(addr + 1 + off));
            default: return {6'h20 + 6'(next_rand() % 8), 26'(next_rand())};  // unsupported
        endcase
    endfunction

    task automatic build_program();
        for (int a = 0; a < 7; a++) begin
            prog[a] = enc_i(OP_ADDIU, 5'd0, 5'(a + 1), 16'(next_rand()));  // defines r1..r7
        end
        for (int a = 7; a < LOOP_ADDR; a++) begin
            prog[a] = random_instr(a);
        end
        prog[LOOP_ADDR] = enc_j(OP_J, 26'(LOOP_ADDR));
        for (int a = 0; a <= LOOP_ADDR; a++) begin
            load_word(8'(a), prog[a]);
        end
    endtask

    // one classic cycle entered and left 1 ns after a rising edge
    task automatic wb_cycle(input logic we, input int adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = 30'(adr);
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (wb_ack !== 1'b1 && waited < 8);
        if (wb_ack !== 1'b1) begin
            $display("ERROR: no Wishbone ack within 8 cycles at address %0d", adr);
            stop_on_error();
        end
        check_value("wb_ack delay", 32'(waited), 32'd1);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
        check_value("wb_ack", {31'd0, wb_ack}, 32'd0);  // single cycle pulse
    endtask

    task automatic run_program();
        logic [29:0] epc;
        logic        ewe;
        logic [4:0]  ereg;
        logic [31:0] edata;
        bit          done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            if (commit_valid === 1'b1) begin
                model_step(epc, ewe, ereg, edata);
                check_value("commit_pc", {2'b00, commit_pc}, {2'b00, epc});
                check_value("commit_we", {31'd0, commit_we}, {31'd0, ewe});
                if (ewe) begin
                    check_value("commit_reg", {27'd0, commit_reg}, {27'd0, ereg});
                    check_value("commit_data", commit_data, edata);
                    seen[ereg[2:0]] = commit_data;
                end
                done = (epc == 30'(LOOP_ADDR));
            end
        end
    endtask

    // nothing may retire while the core is held, and no ack during reset
    always @(posedge clk) begin
        if (rst === 1'b1 && wb_ack === 1'b1) begin
            $display("ERROR: wb_ack high during reset");
            stop_on_error();
        end
        if (run === 1'b0 && commit_valid === 1'b1) begin
            $display("ERROR: commit_valid high while run is low");
            stop_on_error();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before the program reached its self loop");
        stop_on_error();
    end

    initial begin
        logic [31:0] rdata;
        rst      = 1'b1;
        run      = 1'b0;
        wb_cyc   = 1'b1;                             // read request held through reset
        wb_stb   = 1'b1;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        foreach (seen[i]) begin
            seen[i] = '0;
        end
        model_reset();
        build_program();
        repeat (3) @(posedge clk);
        #1;
        rst    = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(posedge clk);
        #1;
        for (int a = 0; a <= LOOP_ADDR; a++) begin
            wb_cycle(1'b1, a, prog[a], rdata);
        end
        for (int a = 0; a <= LOOP_ADDR; a++) begin
            wb_cycle(1'b0, a, '0, rdata);
            check_value($sformatf("wb_dat_r[%0d]", a), rdata, prog[a]);
        end
        run = 1'b1;
        run_program();
        for (int i = 1; i < 8; i++) begin
            check_value($sformatf("final r%0d", i), seen[i], reg_value(5'(i)));
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
logic/mips_pkg.sv
logic/stage_if.sv
logic/ifetch.sv
logic/decode.sv
logic/execute.sv
logic/result.sv
logic/reg_file.sv
logic/mips_core.sv
sim/mips_model.sv
sim/mips_core_tb.sv
